// File: Makefile
TOP := id_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) \
		-f rv32i_decode.f -Mdir obj_dir
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "^Finished with no errors$$" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

// File: design/branch_cmp.sv
`default_nettype none

module branch_cmp (
    input  wire rv32i_isa_pkg::branch_funct3_t  cmpop_i,
    input  wire logic [rv32i_isa_pkg::XLEN-1:0] a_i,
    input  wire logic [rv32i_isa_pkg::XLEN-1:0] b_i,
    output logic                                br_en_o
);

    logic eq;
    logic lt_s;
    logic lt_u;

    assign eq   = (a_i == b_i);
    assign lt_s = ($signed(a_i) < $signed(b_i));
    assign lt_u = (a_i < b_i);

    always_comb begin
        case (cmpop_i)
            rv32i_isa_pkg::beq:  br_en_o = eq;
            rv32i_isa_pkg::bne:  br_en_o = !eq;
            rv32i_isa_pkg::blt:  br_en_o = lt_s;
            rv32i_isa_pkg::bge:  br_en_o = !lt_s;
            rv32i_isa_pkg::bltu: br_en_o = lt_u;
            rv32i_isa_pkg::bgeu: br_en_o = !lt_u;
            default:             br_en_o = 1'b0;   // funct3 010 and 011.
        endcase
    end

endmodule

`default_nettype wire

// File: design/control_rom.sv
`default_nettype none

module control_rom (
    input  wire rv32i_isa_pkg::rv32i_opcode     opcode_i,
    input  wire logic [2:0]                     funct3_i,
    input  wire logic [6:0]                     funct7_i,
    output rv32i_ctrl_pkg::rv32i_control_word   ctrl_o
);

    logic is_reg;

    assign is_reg = (opcode_i == rv32i_isa_pkg::op_reg);

    always_comb begin
        // defaults, a plain rs1 + i_imm add that writes nothing.
        ctrl_o.opcode         = opcode_i;
        ctrl_o.aluop          = rv32i_ctrl_pkg::alu_add;
        ctrl_o.cmpop          = rv32i_isa_pkg::branch_funct3_t'(funct3_i);
        ctrl_o.cmpmux_sel     = rv32i_ctrl_pkg::cmpmux_rs2;
        ctrl_o.alumux1_sel    = rv32i_ctrl_pkg::alumux1_rs1;
        ctrl_o.alumux2_sel    = rv32i_ctrl_pkg::alumux2_i_imm;
        ctrl_o.regfilemux_sel = rv32i_ctrl_pkg::regfilemux_alu_out;
        ctrl_o.load_regfile   = 1'b0;
        ctrl_o.mem_read       = 1'b0;
        ctrl_o.mem_write      = 1'b0;
        ctrl_o.illegal        = 1'b0;

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        case (opcode_i)
            rv32i_isa_pkg::op_lui: begin
                ctrl_o.load_regfile   = 1'b1;
                ctrl_o.regfilemux_sel = rv32i_ctrl_pkg::regfilemux_u_imm;
            end
            rv32i_isa_pkg::op_auipc: begin
                ctrl_o.load_regfile = 1'b1;
                ctrl_o.alumux1_sel  = rv32i_ctrl_pkg::alumux1_pc;
                ctrl_o.alumux2_sel  = rv32i_ctrl_pkg::alumux2_u_imm;
            end
            rv32i_isa_pkg::op_jal: begin
                ctrl_o.load_regfile   = 1'b1;
                ctrl_o.alumux1_sel    = rv32i_ctrl_pkg::alumux1_pc;
                ctrl_o.alumux2_sel    = rv32i_ctrl_pkg::alumux2_j_imm;
                ctrl_o.regfilemux_sel = rv32i_ctrl_pkg::regfilemux_pc_plus4;
            end
            rv32i_isa_pkg::op_jalr: begin
                ctrl_o.load_regfile   = 1'b1;
                ctrl_o.regfilemux_sel = rv32i_ctrl_pkg::regfilemux_pc_plus4;
            end
            rv32i_isa_pkg::op_br: begin   // target is pc + b_imm.
                ctrl_o.alumux1_sel = rv32i_ctrl_pkg::alumux1_pc;
                ctrl_o.alumux2_sel = rv32i_ctrl_pkg::alumux2_b_imm;
            end
            rv32i_isa_pkg::op_load: begin
                ctrl_o.load_regfile   = 1'b1;
                ctrl_o.mem_read       = 1'b1;
                ctrl_o.regfilemux_sel = rv32i_ctrl_pkg::regfilemux_lw;
            end
            rv32i_isa_pkg::op_store: begin
                ctrl_o.mem_write   = 1'b1;
                ctrl_o.alumux2_sel = rv32i_ctrl_pkg::alumux2_s_imm;
            end
            rv32i_isa_pkg::op_imm, rv32i_isa_pkg::op_reg: begin
                ctrl_o.load_regfile = 1'b1;
                if (is_reg) begin
                    ctrl_o.alumux2_sel = rv32i_ctrl_pkg::alumux2_rs2;
                    ctrl_o.illegal     = (funct7_i != rv32i_isa_pkg::FUNCT7_BASE) &&
                                         (funct7_i != rv32i_isa_pkg::FUNCT7_ALT);
                end
                case (funct3_i)
                    3'b000: ctrl_o.aluop = (is_reg && funct7_i[5]) ?
                                           rv32i_ctrl_pkg::alu_sub : rv32i_ctrl_pkg::alu_add;
                    3'b001: ctrl_o.aluop = rv32i_ctrl_pkg::alu_sll;
                    3'b010, 3'b011: begin   // slt forms go through the comparator.
                        ctrl_o.cmpop          = funct3_i[0] ? rv32i_isa_pkg::bltu
                                                            : rv32i_isa_pkg::blt;
                        ctrl_o.cmpmux_sel     = is_reg ? rv32i_ctrl_pkg::cmpmux_rs2
                                                       : rv32i_ctrl_pkg::cmpmux_i_imm;
                        ctrl_o.regfilemux_sel = rv32i_ctrl_pkg::regfilemux_br_en;
                    end
                    3'b100: ctrl_o.aluop = rv32i_ctrl_pkg::alu_xor;
                    3'b101: ctrl_o.aluop = funct7_i[5] ? rv32i_ctrl_pkg::alu_sra
                                                       : rv32i_ctrl_pkg::alu_srl;
                    3'b110: ctrl_o.aluop = rv32i_ctrl_pkg::alu_or;
                    default: ctrl_o.aluop = rv32i_ctrl_pkg::alu_and;
                endcase
            end
            default: ctrl_o.illegal = 1'b1;   // unknown opcode.
        endcase

        if (ctrl_o.illegal) begin
            ctrl_o.load_regfile = 1'b0;
            ctrl_o.mem_write    = 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: design/id_ex_reg.sv
`default_nettype none

module id_ex_reg (
    input  wire logic                   clk,
    input  wire logic                   rst_i,
    input  wire logic                   stall_i,
    input  wire rv32i_ctrl_pkg::id_ex_t decoded_i,
    output rv32i_ctrl_pkg::id_ex_t      id_ex_o
);

    logic                   valid_q;
    rv32i_ctrl_pkg::id_ex_t record_q;

    // a stall cycle becomes one bubble downstream.
    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= decoded_i.valid && !stall_i;
        end
    end

    always_ff @(posedge clk) begin
        record_q <= decoded_i;
    end

    always_comb begin
        id_ex_o       = record_q;
        id_ex_o.valid = valid_q;   // only the registered valid counts.
    end

endmodule

`default_nettype wire

// File: design/id_stage.sv
`default_nettype none

module id_stage (
    input  wire logic                           clk,
    input  wire logic                           rst_i,
    input  wire rv32i_ctrl_pkg::if_id_t         ifid_i,
    input  wire logic                           wb_load_i,
    input  wire rv32i_isa_pkg::reg_idx_t        wb_rd_i,
    input  wire logic [rv32i_isa_pkg::XLEN-1:0] wb_data_i,
    output rv32i_ctrl_pkg::id_ex_t              decoded_o
);

    logic [rv32i_isa_pkg::XLEN-1:0]    instr;
    rv32i_isa_pkg::rv32i_opcode        opcode;
    logic [2:0]                        funct3;
    logic [6:0]                        funct7;
    rv32i_isa_pkg::reg_idx_t           rs1;
    rv32i_isa_pkg::reg_idx_t           rs2;
    rv32i_isa_pkg::reg_idx_t           rd;
    rv32i_isa_pkg::rv32i_imm_t         imm;
    rv32i_ctrl_pkg::rv32i_control_word ctrl;
    logic [rv32i_isa_pkg::XLEN-1:0]    rs1_data;
    logic [rv32i_isa_pkg::XLEN-1:0]    rs2_data;
    logic [rv32i_isa_pkg::XLEN-1:0]    cmp_b;
    logic                              br_en;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign instr  = ifid_i.instr;
    assign opcode = rv32i_isa_pkg::rv32i_opcode'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign rd     = instr[11:7];

    assign imm.i = {{21{instr[31]}}, instr[30:20]};
    assign imm.s = {{21{instr[31]}}, instr[30:25], instr[11:7]};
    assign imm.b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm.u = {instr[31:12], 12'h000};
    assign imm.j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    assign cmp_b = (ctrl.cmpmux_sel == rv32i_ctrl_pkg::cmpmux_i_imm) ? imm.i : rs2_data;

    control_rom control_rom_i (
        .opcode_i (opcode),
        .funct3_i (funct3),
        .funct7_i (funct7),
        .ctrl_o   (ctrl)
    );

    regfile regfile_i (
        .clk        (clk),
        .rst_i      (rst_i),
        .load_i     (wb_load_i),
        .wr_idx_i   (wb_rd_i),
        .wr_data_i  (wb_data_i),
        .rs1_idx_i  (rs1),
        .rs2_idx_i  (rs2),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    branch_cmp branch_cmp_i (
        .cmpop_i (ctrl.cmpop),
        .a_i     (rs1_data),
        .b_i     (cmp_b),
        .br_en_o (br_en)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        decoded_o.valid    = ifid_i.valid;
        decoded_o.ctrl     = ctrl;
        decoded_o.instr    = instr;
        decoded_o.pc       = ifid_i.pc;
        decoded_o.rs1_data = rs1_data;
        decoded_o.rs2_data = rs2_data;
        decoded_o.imm      = imm;
        decoded_o.rd       = rd;
        decoded_o.br_en    = br_en;
    end

endmodule

`default_nettype wire

// File: design/id_top.sv
`default_nettype none

module id_top (
    input  wire logic                           clk,
    input  wire logic                           rst_i,
    input  wire logic                           fetch_valid_i,
    input  wire logic [rv32i_isa_pkg::XLEN-1:0] fetch_instr_i,
    input  wire logic [rv32i_isa_pkg::XLEN-1:0] fetch_pc_i,
    input  wire logic                           stall_i,
    input  wire logic                           flush_i,
    input  wire logic                           wb_load_i,
    input  wire rv32i_isa_pkg::reg_idx_t        wb_rd_i,
    input  wire logic [rv32i_isa_pkg::XLEN-1:0] wb_data_i,
    output rv32i_ctrl_pkg::id_ex_t              id_ex_o
);

    rv32i_ctrl_pkg::if_id_t ifid;
    rv32i_ctrl_pkg::id_ex_t decoded;

    if_id_reg if_id_reg_i (
        .clk           (clk),
        .rst_i         (rst_i),
        .stall_i       (stall_i),
        .flush_i       (flush_i),
        .fetch_valid_i (fetch_valid_i),
        .fetch_instr_i (fetch_instr_i),
        .fetch_pc_i    (fetch_pc_i),
        .ifid_o        (ifid)
    );

    id_stage id_stage_i (
        .clk       (clk),
        .rst_i     (rst_i),
        .ifid_i    (ifid),
        .wb_load_i (wb_load_i),
        .wb_rd_i   (wb_rd_i),
        .wb_data_i (wb_data_i),
        .decoded_o (decoded)
    );

    id_ex_reg id_ex_reg_i (
        .clk       (clk),
        .rst_i     (rst_i),
        .stall_i   (stall_i),
        .decoded_i (decoded),
        .id_ex_o   (id_ex_o)
    );

endmodule

`default_nettype wire

// File: design/if_id_reg.sv
`default_nettype none

module if_id_reg (
    input  wire logic                           clk,
    input  wire logic                           rst_i,
    input  wire logic                           stall_i,
    input  wire logic                           flush_i,
    input  wire logic                           fetch_valid_i,
    input  wire logic [rv32i_isa_pkg::XLEN-1:0] fetch_instr_i,
    input  wire logic [rv32i_isa_pkg::XLEN-1:0] fetch_pc_i,
    output rv32i_ctrl_pkg::if_id_t              ifid_o
);

    logic                           valid_q;
    logic [rv32i_isa_pkg::XLEN-1:0] pc_q;
    logic [rv32i_isa_pkg::XLEN-1:0] instr_q;

    // flush beats stall, stall beats load.
    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            valid_q <= 1'b0;
        end else if (!stall_i) begin
            valid_q <= fetch_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            pc_q    <= fetch_pc_i;
            instr_q <= fetch_instr_i;
        end
    end

    assign ifid_o.valid = valid_q;
    assign ifid_o.pc    = pc_q;
    assign ifid_o.instr = instr_q;

endmodule

`default_nettype wire

// File: design/regfile.sv
`default_nettype none

module regfile (
    input  wire logic                           clk,
    input  wire logic                           rst_i,
    input  wire logic                           load_i,
    input  wire rv32i_isa_pkg::reg_idx_t        wr_idx_i,
    input  wire logic [rv32i_isa_pkg::XLEN-1:0] wr_data_i,
    input  wire rv32i_isa_pkg::reg_idx_t        rs1_idx_i,
    input  wire rv32i_isa_pkg::reg_idx_t        rs2_idx_i,
    output logic [rv32i_isa_pkg::XLEN-1:0]      rs1_data_o,
    output logic [rv32i_isa_pkg::XLEN-1:0]      rs2_data_o
);

    logic [rv32i_isa_pkg::XLEN-1:0] regs [rv32i_isa_pkg::NUM_REGS];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < rv32i_isa_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (load_i && (wr_idx_i != '0)) begin   // x0 is never written.
            regs[wr_idx_i] <= wr_data_i;
        end
    end

    // one read port, x0 first, then the write bypass.
    function automatic logic [rv32i_isa_pkg::XLEN-1:0] read_port(
        input rv32i_isa_pkg::reg_idx_t idx
    );
        logic [rv32i_isa_pkg::XLEN-1:0] val;
        if (idx == '0) begin
            val = '0;
        end else if (load_i && (wr_idx_i == idx)) begin
            val = wr_data_i;   // same-cycle write seen by the reader.
        end else begin
            val = regs[idx];
        end
        return val;
    endfunction

    always_comb begin
        rs1_data_o = read_port(rs1_idx_i);
        rs2_data_o = read_port(rs2_idx_i);
    end

endmodule

`default_nettype wire

// File: design/rv32i_ctrl_pkg.sv
`default_nettype none

package rv32i_ctrl_pkg;

    typedef enum logic [2:0] {
        alu_add = 3'b000,
        alu_sll = 3'b001,
        alu_sra = 3'b010,
        alu_sub = 3'b011,
        alu_xor = 3'b100,
        alu_srl = 3'b101,
        alu_or  = 3'b110,
        alu_and = 3'b111
    } alu_ops_t;

    typedef enum logic {
        cmpmux_rs2   = 1'b0,
        cmpmux_i_imm = 1'b1
    } cmpmux_sel_t;

    typedef enum logic {
        alumux1_rs1 = 1'b0,
        alumux1_pc  = 1'b1
    } alumux1_sel_t;

    typedef enum logic [2:0] {
        alumux2_i_imm = 3'b000,
        alumux2_u_imm = 3'b001,
        alumux2_b_imm = 3'b010,
        alumux2_s_imm = 3'b011,
        alumux2_j_imm = 3'b100,
        alumux2_rs2   = 3'b101
    } alumux2_sel_t;

    typedef enum logic [2:0] {
        regfilemux_alu_out  = 3'b000,
        regfilemux_br_en    = 3'b001,
        regfilemux_u_imm    = 3'b010,
        regfilemux_lw       = 3'b011,
        regfilemux_pc_plus4 = 3'b100
    } regfilemux_sel_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        rv32i_isa_pkg::rv32i_opcode    opcode;
        alu_ops_t                      aluop;
        rv32i_isa_pkg::branch_funct3_t cmpop;
        cmpmux_sel_t                   cmpmux_sel;
        alumux1_sel_t                  alumux1_sel;
        alumux2_sel_t                  alumux2_sel;
        regfilemux_sel_t               regfilemux_sel;
        logic                          load_regfile;
        logic                          mem_read;
        logic                          mem_write;
        logic                          illegal;
    } rv32i_control_word;

    typedef struct packed {
        logic                           valid;
        logic [rv32i_isa_pkg::XLEN-1:0] pc;
        logic [rv32i_isa_pkg::XLEN-1:0] instr;
    } if_id_t;

    typedef struct packed {
        logic                           valid;
        rv32i_control_word              ctrl;
        logic [rv32i_isa_pkg::XLEN-1:0] instr;
        logic [rv32i_isa_pkg::XLEN-1:0] pc;
        logic [rv32i_isa_pkg::XLEN-1:0] rs1_data;
        logic [rv32i_isa_pkg::XLEN-1:0] rs2_data;
        rv32i_isa_pkg::rv32i_imm_t      imm;
        rv32i_isa_pkg::reg_idx_t        rd;
        logic                           br_en;
    } id_ex_t;

endpackage

`default_nettype wire

// File: design/rv32i_isa_pkg.sv
`default_nettype none

package rv32i_isa_pkg;

    localparam int XLEN = 32;
    localparam int NUM_REGS = 32;

    // funct7 values accepted on the reg format.
    localparam logic [6:0] FUNCT7_BASE = 7'h00;
    localparam logic [6:0] FUNCT7_ALT  = 7'h20;

    typedef logic [4:0] reg_idx_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // major opcodes, low seven bits of the instruction.
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } rv32i_opcode;

    typedef enum logic [2:0] {
        beq  = 3'b000,
        bne  = 3'b001,
        blt  = 3'b100,
        bge  = 3'b101,
        bltu = 3'b110,
        bgeu = 3'b111
    } branch_funct3_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // all immediates are sign extended to full width.
    typedef struct packed {
        logic [XLEN-1:0] i;
        logic [XLEN-1:0] s;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] u;
        logic [XLEN-1:0] j;
    } rv32i_imm_t;

endpackage

`default_nettype wire

// File: rv32i_decode.f
design/rv32i_isa_pkg.sv
design/rv32i_ctrl_pkg.sv
design/if_id_reg.sv
design/regfile.sv
design/control_rom.sv
design/branch_cmp.sv
design/id_stage.sv
design/id_ex_reg.sv
design/id_top.sv
verification/id_top_sva.sv
verification/id_tb.sv

// File: verification/id_tb.sv
`default_nettype none

module id_tb;

    timeunit 1ns;
    timeprecision 100ps;

    logic                    clk;
    logic                    rst_i;
    logic                    fetch_valid_i;
    logic [31:0]             fetch_instr_i;
    logic [31:0]             fetch_pc_i;
    logic                    stall_i;
    logic                    flush_i;
    logic                    wb_load_i;
    rv32i_isa_pkg::reg_idx_t wb_rd_i;
    logic [31:0]             wb_data_i;
    rv32i_ctrl_pkg::id_ex_t  id_ex_o;

    integer seed;
    int     errors;
    int     checks;
    int     records;
    int     bubbles;

    // model of the pipeline and the register file.
    logic [31:0]            model_regs [32];
    logic                   m_ifid_valid;
    logic [31:0]            m_ifid_instr;
    logic [31:0]            m_ifid_pc;
    logic                   exp_valid;
    rv32i_ctrl_pkg::id_ex_t exp_rec;
    logic [63:0]            pending [$];   // {pc, instr} in fetch order.

    id_top id_top_i (
        .clk           (clk),
        .rst_i         (rst_i),
        .fetch_valid_i (fetch_valid_i),
        .fetch_instr_i (fetch_instr_i),
        .fetch_pc_i    (fetch_pc_i),
        .stall_i       (stall_i),
        .flush_i       (flush_i),
        .wb_load_i     (wb_load_i),
        .wb_rd_i       (wb_rd_i),
        .wb_data_i     (wb_data_i),
        .id_ex_o       (id_ex_o)
    );

    always begin
        #5 clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // expected record from the RV32I format rules.
    function automatic rv32i_ctrl_pkg::id_ex_t decode_ref(
        input logic [31:0] instr,
        input logic [31:0] pc,
        input logic [31:0] a,
        input logic [31:0] rs2v
    );
        rv32i_ctrl_pkg::id_ex_t            r;
        rv32i_ctrl_pkg::rv32i_control_word c;
        logic [2:0]                        f3;
        logic [6:0]                        f7;
        logic [2:0]                        cmp;
        logic [31:0]                       b;
        logic                              is_reg;
        f3 = instr[14:12];
        f7 = instr[31:25];
        cmp = f3;
        is_reg = (instr[6:0] == rv32i_isa_pkg::op_reg);

        r.imm.i = {{20{instr[31]}}, instr[31:20]};
        r.imm.s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
        r.imm.b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
        r.imm.u = {instr[31:12], 12'b0};
        r.imm.j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

        c.opcode         = rv32i_isa_pkg::rv32i_opcode'(instr[6:0]);
        c.aluop          = rv32i_ctrl_pkg::alu_add;
        c.cmpmux_sel     = rv32i_ctrl_pkg::cmpmux_rs2;
        c.alumux1_sel    = rv32i_ctrl_pkg::alumux1_rs1;
        c.alumux2_sel    = rv32i_ctrl_pkg::alumux2_i_imm;
        c.regfilemux_sel = rv32i_ctrl_pkg::regfilemux_alu_out;
        c.load_regfile   = 1'b0;
        c.mem_read       = 1'b0;
        c.mem_write      = 1'b0;
        c.illegal        = 1'b0;

        case (instr[6:0])
            rv32i_isa_pkg::op_lui: begin
                c.load_regfile   = 1'b1;
                c.regfilemux_sel = rv32i_ctrl_pkg::regfilemux_u_imm;
            end
            rv32i_isa_pkg::op_auipc: begin
                c.load_regfile = 1'b1;
                c.alumux1_sel  = rv32i_ctrl_pkg::alumux1_pc;
                c.alumux2_sel  = rv32i_ctrl_pkg::alumux2_u_imm;
            end
            rv32i_isa_pkg::op_jal: begin
                c.load_regfile   = 1'b1;
                c.alumux1_sel    = rv32i_ctrl_pkg::alumux1_pc;
                c.alumux2_sel    = rv32i_ctrl_pkg::alumux2_j_imm;
                c.regfilemux_sel = rv32i_ctrl_pkg::regfilemux_pc_plus4;
            end
            rv32i_isa_pkg::op_jalr: begin
                c.load_regfile   = 1'b1;
                c.regfilemux_sel = rv32i_ctrl_pkg::regfilemux_pc_plus4;
            end
            rv32i_isa_pkg::op_br: begin
                c.alumux1_sel = rv32i_ctrl_pkg::alumux1_pc;
                c.alumux2_sel = rv32i_ctrl_pkg::alumux2_b_imm;
            end
            rv32i_isa_pkg::op_load: begin
                c.load_regfile   = 1'b1;
                c.mem_read       = 1'b1;
                c.regfilemux_sel = rv32i_ctrl_pkg::regfilemux_lw;
            end
            rv32i_isa_pkg::op_store: begin
                c.mem_write   = 1'b1;
                c.alumux2_sel = rv32i_ctrl_pkg::alumux2_s_imm;
            end
            rv32i_isa_pkg::op_imm, rv32i_isa_pkg::op_reg: begin
                c.load_regfile = 1'b1;
                c.illegal      = is_reg && (f7 != 7'h00) && (f7 != 7'h20);
                if (is_reg) begin
                    c.alumux2_sel = rv32i_ctrl_pkg::alumux2_rs2;
                end
                case (f3)
                    3'd0: c.aluop = (is_reg && f7[5]) ? rv32i_ctrl_pkg::alu_sub
                                                      : rv32i_ctrl_pkg::alu_add;
                    3'd1: c.aluop = rv32i_ctrl_pkg::alu_sll;
                    3'd4: c.aluop = rv32i_ctrl_pkg::alu_xor;
                    3'd5: c.aluop = f7[5] ? rv32i_ctrl_pkg::alu_sra : rv32i_ctrl_pkg::alu_srl;
                    3'd6: c.aluop = rv32i_ctrl_pkg::alu_or;
                    3'd7: c.aluop = rv32i_ctrl_pkg::alu_and;
                    default: begin   // slt and sltu.
                        cmp = f3[0] ? 3'b110 : 3'b100;
                        if (!is_reg) begin
                            c.cmpmux_sel = rv32i_ctrl_pkg::cmpmux_i_imm;
                        end
                        c.regfilemux_sel = rv32i_ctrl_pkg::regfilemux_br_en;
                    end
                endcase
            end
            default: c.illegal = 1'b1;
        endcase
        if (c.illegal) begin
            c.load_regfile = 1'b0;
            c.mem_write    = 1'b0;
        end
        c.cmpop = rv32i_isa_pkg::branch_funct3_t'(cmp);

        b = (c.cmpmux_sel == rv32i_ctrl_pkg::cmpmux_i_imm) ? r.imm.i : rs2v;
        case (cmp)
            3'b000: r.br_en = (a == b);
            3'b001: r.br_en = (a != b);
            3'b100: r.br_en = ($signed(a) < $signed(b));
            3'b101: r.br_en = ($signed(a) >= $signed(b));
            3'b110: r.br_en = (a < b);
            3'b111: r.br_en = (a >= b);
            default: r.br_en = 1'b0;
        endcase

        r.valid    = 1'b1;
        r.ctrl     = c;
        r.instr    = instr;
        r.pc       = pc;
        r.rs1_data = a;
        r.rs2_data = rs2v;
        r.rd       = instr[11:7];
        return r;
    endfunction

    // register read as seen in the current cycle.
    function automatic logic [31:0] model_read(input logic [4:0] idx);
        if (idx == 5'd0) begin
            return 32'h0;
        end
        if (wb_load_i && (wb_rd_i == idx)) begin
            return wb_data_i;
        end
        return model_regs[idx];
    endfunction

    function automatic logic [31:0] random_instr();
        logic [31:0] w;
        logic [31:0] r;
        int          pick;
        w = $random(seed);
        r = $random(seed);
        pick = $unsigned($random(seed)) % 11;
        if (r[0]) begin   // low indices, so writes and reads collide.
            w[19:18] = 2'b00;
            w[24:23] = 2'b00;
        end
        case (pick)
            0: w[6:0] = rv32i_isa_pkg::op_lui;
            1: w[6:0] = rv32i_isa_pkg::op_auipc;
            2: w[6:0] = rv32i_isa_pkg::op_jal;
            3: w[6:0] = rv32i_isa_pkg::op_jalr;
            4: w[6:0] = rv32i_isa_pkg::op_br;
            5: w[6:0] = rv32i_isa_pkg::op_load;
            6: w[6:0] = rv32i_isa_pkg::op_store;
            7: w[6:0] = rv32i_isa_pkg::op_imm;
            8: w[6:0] = rv32i_isa_pkg::op_reg;
            9: w[6:0] = 7'h73;
            default: w[6:0] = 7'h0f;
        endcase
        if ((pick == 8) && (r[2:1] != 2'b00)) begin
            w[31:25] = r[3] ? 7'h20 : 7'h00;
        end
        return w;
    endfunction

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < 32; i++) begin
                model_regs[i] = 32'h0;
            end
            m_ifid_valid = 1'b0;
            exp_valid = 1'b0;
            pending.delete();
        end else begin
            exp_valid = m_ifid_valid && !stall_i;
            if (m_ifid_valid) begin
                exp_rec = decode_ref(m_ifid_instr, m_ifid_pc,
                                     model_read(m_ifid_instr[19:15]),
                                     model_read(m_ifid_instr[24:20]));
            end
            if (flush_i && stall_i && m_ifid_valid) begin
                void'(pending.pop_back());   // held instruction is dropped.
            end
            if (!stall_i) begin
                m_ifid_instr = fetch_instr_i;
                m_ifid_pc = fetch_pc_i;
                m_ifid_valid = fetch_valid_i && !flush_i;
                if (m_ifid_valid) begin
                    pending.push_back({fetch_pc_i, fetch_instr_i});
                end
            end else if (flush_i) begin
                m_ifid_valid = 1'b0;
            end
            if (wb_load_i && (wb_rd_i != 5'd0)) begin
                model_regs[wb_rd_i] = wb_data_i;
            end
        end
    end

    always @(negedge clk) begin
        logic [63:0] sent;
        check_field("id_ex_o.valid", 32'(id_ex_o.valid), 32'(exp_valid));
        if (exp_valid && (id_ex_o.valid === 1'b1)) begin
            records++;
            check_field("id_ex_o.instr", id_ex_o.instr, exp_rec.instr);
            check_field("id_ex_o.pc", id_ex_o.pc, exp_rec.pc);
            check_field("id_ex_o.rd", 32'(id_ex_o.rd), 32'(exp_rec.rd));
            check_field("id_ex_o.ctrl", 32'(id_ex_o.ctrl), 32'(exp_rec.ctrl));
            check_field("id_ex_o.rs1_data", id_ex_o.rs1_data, exp_rec.rs1_data);
            check_field("id_ex_o.rs2_data", id_ex_o.rs2_data, exp_rec.rs2_data);
            check_field("id_ex_o.imm.i", id_ex_o.imm.i, exp_rec.imm.i);
            check_field("id_ex_o.imm.s", id_ex_o.imm.s, exp_rec.imm.s);
            check_field("id_ex_o.imm.b", id_ex_o.imm.b, exp_rec.imm.b);
            check_field("id_ex_o.imm.u", id_ex_o.imm.u, exp_rec.imm.u);
            check_field("id_ex_o.imm.j", id_ex_o.imm.j, exp_rec.imm.j);
            check_field("id_ex_o.br_en", 32'(id_ex_o.br_en), 32'(exp_rec.br_en));
            if (pending.size() == 0) begin
                errors++;
                $display("valid ID/EX record at %0t with no instruction pending", $time);
            end else begin
                sent = pending.pop_front();
                check_field("id_ex_o.instr in order", id_ex_o.instr, sent[31:0]);
                check_field("id_ex_o.pc in order", id_ex_o.pc, sent[63:32]);
            end
        end else if (!rst_i) begin
            bubbles++;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        logic [31:0] pc;
        logic [31:0] r;
        int          wait_cycles;
        seed = 32'h0ec67986;
        errors = 0;
        checks = 0;
        records = 0;
        bubbles = 0;
        pc = 32'h0000_1000;
        clk = 1'b0;
        rst_i = 1'b1;
        fetch_valid_i = 1'b0;
        fetch_instr_i = 32'h0;
        fetch_pc_i = 32'h0;
        stall_i = 1'b0;
        flush_i = 1'b0;
        wb_load_i = 1'b0;
        wb_rd_i = 5'd0;
        wb_data_i = 32'h0;
        repeat (10) @(posedge clk);
        rst_i <= 1'b0;

        // read every register once while the file is still clear.
        for (int i = 0; i < 16; i++) begin
            @(posedge clk);
            fetch_valid_i <= 1'b1;
            fetch_instr_i <= {7'h00, 5'(2 * i + 1), 5'(2 * i), 3'b000, 5'd0,
                              rv32i_isa_pkg::op_reg};
            fetch_pc_i <= pc;
            pc = pc + 32'd4;
        end

        for (int n = 0; n < 3000; n++) begin
            @(posedge clk);
            r = $random(seed);
            fetch_valid_i <= r[0] | r[1];
            fetch_instr_i <= random_instr();
            fetch_pc_i <= pc;
            stall_i <= (r[4:2] == 3'd0);
            flush_i <= (r[7:5] == 3'd0);
            wb_load_i <= r[8];
            wb_rd_i <= r[12] ? r[17:13] : {2'b00, r[11:9]};
            wb_data_i <= $random(seed);
            pc = pc + 32'd4;
        end

        @(posedge clk);
        fetch_valid_i <= 1'b0;
        stall_i <= 1'b0;
        flush_i <= 1'b0;
        wb_load_i <= 1'b0;
        @(negedge clk);
        wait_cycles = 0;
        while ((pending.size() != 0) && (wait_cycles < 20)) begin
            @(posedge clk);
            wait_cycles++;
        end
        if (pending.size() != 0) begin
            errors++;
            $display("timeout while draining, %0d instructions never left ID/EX",
                     pending.size());
        end
        repeat (2) @(posedge clk);

        $display("records %0d, bubbles %0d, checks %0d, errors %0d",
                 records, bubbles, checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verification/id_top_sva.sv
`default_nettype none

module id_top_sva (
    input wire logic                   clk,
    input wire logic                   rst_i,
    input wire logic                   stall_i,
    input wire rv32i_ctrl_pkg::id_ex_t decoded_i,
    input wire rv32i_ctrl_pkg::id_ex_t id_ex_i
);

    timeunit 1ns;
    timeprecision 100ps;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    reset_clears_valid: assert property (
        @(posedge clk) rst_i |=> !id_ex_i.valid
    ) else $error("ID/EX valid high during or right after reset");

    // x0 reads as zero on both ports.
    rs1_x0_zero: assert property (
        @(posedge clk) disable iff (rst_i)
        (decoded_i.valid && (decoded_i.instr[19:15] == 5'd0)) |-> (decoded_i.rs1_data == '0)
    ) else $error("rs1 data nonzero for x0");

    rs2_x0_zero: assert property (
        @(posedge clk) disable iff (rst_i)
        (decoded_i.valid && (decoded_i.instr[24:20] == 5'd0)) |-> (decoded_i.rs2_data == '0)
    ) else $error("rs2 data nonzero for x0");

    stall_gives_bubble: assert property (
        @(posedge clk) disable iff (rst_i) stall_i |=> !id_ex_i.valid
    ) else $error("stall cycle did not produce a bubble");

endmodule

bind id_top id_top_sva id_top_sva_i (
    .clk       (clk),
    .rst_i     (rst_i),
    .stall_i   (stall_i),
    .decoded_i (decoded),
    .id_ex_i   (id_ex_o)
);

`default_nettype wire
